/* src/rv32i_types.sv */
package rv32i_types;

    // fetch constants
    localparam logic [31:0] RESET_PC        = 32'h6000_0000; // first fetch address
    localparam logic [31:0] PC_STEP         = 32'd4;         // one rv32i word per fetch
    localparam int          IQ_DEPTH        = 16;            // default queue depth
    localparam int          IQ_DATA_WIDTH   = 64;            // pc plus instruction
    localparam logic [3:0]  IMEM_RMASK_WORD = 4'b1111;       // full 32-bit read

    // one queue slot, pc in the upper half like the decode stage expects
    typedef struct packed {
        logic [31:0] pc;    // address the word was read from
        logic [31:0] instr; // raw instruction bits
    } iq_entry_t;

    // which redirect source won this cycle
    typedef enum logic [2:0] {
        RD_NONE   = 3'd0, // sequential fetch
        RD_FLUSH  = 3'd1, // commit stage mispredict recovery
        RD_JALR   = 3'd2, // jalr target resolved
        RD_JUMP   = 3'd3, // jal target
        RD_BRANCH = 3'd4  // taken branch
    } redirect_e;

endpackage

/* src/pc_reg.sv */
module pc_reg
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,     // commit flush pulse
    input  logic                  jalr_done, // jalr target ready
    input  logic                  jump_en,   // jal pulse
    input  logic                  br_en,     // taken branch pulse
    input  logic [31:0]           missed_pc,
    input  logic [31:0]           jalr_pc,
    input  logic [31:0]           pc_jump,
    input  logic [31:0]           pc_branch,
    input  logic                  advance,   // accepted response, step to next word
    output logic [31:0]           pc,
    output rv32i_types::redirect_e redirect  // winning source this cycle
);
    import rv32i_types::*;

    logic [31:0] pc_next;

    // priority is flush > jalr_done > jump > branch > sequential
    always_comb
    begin
        redirect = RD_NONE;
        pc_next  = pc; // hold unless something moves it
        if (flush)
        begin
            redirect = RD_FLUSH;
            pc_next  = missed_pc;
        end
        else if (jalr_done)
        begin
            redirect = RD_JALR;
            pc_next  = jalr_pc;
        end
        else if (jump_en)
        begin
            redirect = RD_JUMP;
            pc_next  = pc_jump;
        end
        else if (br_en)
        begin
            redirect = RD_BRANCH;
            pc_next  = pc_branch;
        end
        else if (advance)
        begin
            pc_next = pc + PC_STEP; // next sequential word
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= RESET_PC;
        end
        else
        begin
            pc <= pc_next;
        end
    end

    // backend targets are all word aligned in rv32i
    pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00);

endmodule

/* src/imem_req_ctrl.sv */
module imem_req_ctrl
(
    input  logic                   clk,
    input  logic                   rst,
    input  rv32i_types::redirect_e redirect,   // from pc_reg
    input  logic                   jalr_en,    // unresolved jalr seen by decode
    input  logic                   jalr_done,  // jalr resolved
    input  logic                   space_ok,   // queue can take one more word
    input  logic                   imem_resp,  // one-cycle response pulse
    output logic [3:0]             imem_rmask,
    output logic                   accept,     // write this response to the queue
    output logic                   advance     // step pc to the next word
);
    import rv32i_types::*;

    logic pending; // one read in flight
    logic stale;   // in-flight read belongs to an old path
    logic stall;   // waiting on jalr target
    logic start;   // a new read begins this cycle

    // new read only when idle, room left, no stall and no redirect this cycle
    always_comb
    begin
        start = !rst && !pending && space_ok && !stall && !jalr_en &&
                (redirect == RD_NONE);
    end

    // mask held high from the start cycle until the response pulse
    assign imem_rmask = (pending || start) ? IMEM_RMASK_WORD : 4'b0000;

    // a redirect in the response cycle also kills the word
    assign accept  = imem_resp && !stale && (redirect == RD_NONE);
    assign advance = accept; // pc steps only past words that were kept

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pending <= 1'b0;
            stale   <= 1'b0;
            stall   <= 1'b0;
        end
        else
        begin
            if (imem_resp)
                pending <= 1'b0; // read finished
            else if (start)
                pending <= 1'b1;

            if (imem_resp)
                stale <= 1'b0; // stale word dropped here
            else if (pending && (redirect != RD_NONE))
                stale <= 1'b1; // path changed under the read

            if (jalr_done)
                stall <= 1'b0; // target known so fetch resumes
            else if (jalr_en)
                stall <= 1'b1;
        end
    end

    // memory must not answer a read that was never issued
    resp_has_req: assert property (@(posedge clk) disable iff (rst)
        imem_resp |-> pending);

    // request stays up until the memory answers
    mask_steady: assert property (@(posedge clk) disable iff (rst)
        (pending && !imem_resp) |=> (imem_rmask == IMEM_RMASK_WORD));

endmodule

/* src/instr_queue.sv */
module instr_queue
#(
    parameter int DEPTH = rv32i_types::IQ_DEPTH
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear,        // redirect, drop everything
    input  logic                   write_enable,
    input  rv32i_types::iq_entry_t data_in,
    input  logic                   read_enable,  // pop the head at this edge
    output rv32i_types::iq_entry_t data_out,     // head, always visible
    output logic                   empty,
    output logic                   space_ok      // a new read may be issued
);
    import rv32i_types::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [IQ_DATA_WIDTH-1:0] mem [DEPTH]; // entry storage

    logic [PTR_W-1:0] head;      // oldest entry
    logic [PTR_W-1:0] tail;      // next free slot
    logic [CNT_W-1:0] count;     // entries held
    logic [PTR_W-1:0] head_next;
    logic [PTR_W-1:0] tail_next;
    logic [CNT_W:0]   fill_next; // count once this edge's write lands
    logic             full;
    logic             do_write;
    logic             do_read;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // clear wins over both ports
    assign do_write = write_enable && !clear;
    assign do_read  = read_enable && !empty && !clear;

    // wrap explicitly so DEPTH need not be a power of two
    assign head_next = (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
    assign tail_next = (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;

    // the write landing now counts as the pending slot
    assign fill_next = {1'b0, count} + {{CNT_W{1'b0}}, write_enable};
    assign space_ok  = (fill_next < (CNT_W + 1)'(DEPTH));

    assign data_out = iq_entry_t'(mem[head]);

    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[tail] <= data_in;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || clear)
        begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end
        else
        begin
            if (do_write)
                tail <= tail_next;
            if (do_read)
                head <= head_next;

            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or write and pop together
            endcase
        end
    end

    // the request side must have reserved room before the word came back
    no_overflow: assert property (@(posedge clk) disable iff (rst)
        write_enable |-> !full);

endmodule

/* src/fetch.sv */
module fetch
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic [31:0]            missed_pc,
    input  logic                   jalr_en,           // stall until jalr_done
    input  logic                   jalr_done,
    input  logic [31:0]            jalr_pc,
    input  logic                   jump_en,
    input  logic [31:0]            pc_jump,
    input  logic                   br_en,
    input  logic [31:0]            pc_branch,
    input  logic [31:0]            imem_rdata,
    input  logic                   imem_resp,
    input  logic                   request_new_instr, // decode wants the head
    output logic [31:0]            imem_addr,
    output logic [3:0]             imem_rmask,
    output rv32i_types::iq_entry_t instruction,       // queue head
    output logic [31:0]            pc,
    output logic                   read_resp          // head valid and popped
);
    import rv32i_types::*;

    redirect_e redirect;    // agreed redirect for every block
    logic      advance;
    logic      accept;
    logic      space_ok;
    logic      iq_empty;
    logic      iq_pop;
    iq_entry_t iq_entry_in;
    logic      hold_valid;  // a read is on the bus
    logic [31:0] hold_addr; // address of that read

    // pc may move under a read on redirect, so the bus keeps the issued address
    assign imem_addr = hold_valid ? hold_addr : pc;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hold_valid <= 1'b0;
        end
        else if (imem_resp)
        begin
            hold_valid <= 1'b0; // bus free next cycle
        end
        else if (imem_rmask != 4'b0000)
        begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!hold_valid)
        begin
            hold_addr <= pc; // capture in the start cycle
        end
    end

    // pc equals the issued address whenever a word is accepted
    assign iq_entry_in = '{pc: pc, instr: imem_rdata};

    // same-cycle answer to decode
    assign iq_pop    = request_new_instr && !iq_empty;
    assign read_resp = iq_pop;

    pc_reg pc_reg_inst (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .jalr_done (jalr_done),
        .jump_en   (jump_en),
        .br_en     (br_en),
        .missed_pc (missed_pc),
        .jalr_pc   (jalr_pc),
        .pc_jump   (pc_jump),
        .pc_branch (pc_branch),
        .advance   (advance),
        .pc        (pc),
        .redirect  (redirect)
    );

    imem_req_ctrl imem_req_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .redirect   (redirect),
        .jalr_en    (jalr_en),
        .jalr_done  (jalr_done),
        .space_ok   (space_ok),
        .imem_resp  (imem_resp),
        .imem_rmask (imem_rmask),
        .accept     (accept),
        .advance    (advance)
    );

    instr_queue #(
        .DEPTH (IQ_DEPTH)
    ) instr_queue_inst (
        .clk          (clk),
        .rst          (rst),
        .clear        (redirect != RD_NONE), // any redirect empties the queue
        .write_enable (accept),
        .data_in      (iq_entry_in),
        .read_enable  (iq_pop),
        .data_out     (instruction),
        .empty        (iq_empty),
        .space_ok     (space_ok)
    );

    // bus address holds from request start to response
    addr_steady: assert property (@(posedge clk) disable iff (rst)
        ((imem_rmask != 4'b0000) && !imem_resp) |=> $stable(imem_addr));

endmodule

/* bench/imem_model.sv */
module imem_model
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] imem_addr,
    input  logic [3:0]  imem_rmask,
    output logic [31:0] imem_rdata,
    output logic        imem_resp
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] LFSR_SEED = 32'hb6914e1a;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] WORD_KEY  = 32'h1357_9bdf; // word = address ^ key

    logic [31:0] lfsr;
    logic [31:0] step_a;   // one bit taken
    logic [31:0] step_b;   // second bit taken
    logic [2:0]  lat_pick; // 1 to 4 cycles
    logic        busy;     // a read is being served
    logic [2:0]  left;     // cycles until the pulse
    logic [31:0] addr_q;   // latched read address

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    assign step_a   = lfsr_next(lfsr);
    assign step_b   = lfsr_next(step_a);
    assign lat_pick = 3'd1 + {1'b0, step_a[0], step_b[0]};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lfsr       <= LFSR_SEED;
            busy       <= 1'b0;
            left       <= 3'd0;
            addr_q     <= 32'd0;
            imem_rdata <= 32'd0;
            imem_resp  <= 1'b0;
        end
        else
        begin
            imem_resp <= 1'b0; // pulse lasts one cycle
            if (imem_resp)
            begin
                busy <= 1'b0; // ready for the next request
            end
            else if (!busy && imem_rmask != 4'b0000)
            begin
                busy   <= 1'b1;
                addr_q <= imem_addr;
                lfsr   <= step_b; // two bits used per read
                left   <= lat_pick - 3'd1;
                if (lat_pick == 3'd1)
                begin
                    imem_resp  <= 1'b1; // fastest answer
                    imem_rdata <= imem_addr ^ WORD_KEY;
                end
            end
            else if (busy)
            begin
                left <= left - 3'd1;
                if (left == 3'd1)
                begin
                    imem_resp  <= 1'b1;
                    imem_rdata <= addr_q ^ WORD_KEY;
                end
            end
        end
    end

endmodule

/* bench/fetch_tb.sv */
module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv32i_types::*;

    localparam logic [31:0] WORD_KEY   = 32'h1357_9bdf; // word = address ^ key
    localparam logic [31:0] LFSR_SEED  = 32'hb6914e1a;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam int          WAIT_LIMIT = 200; // cycles allowed per wait

    logic        clk;
    logic        rst;
    logic        flush;
    logic [31:0] missed_pc;
    logic        jalr_en;
    logic        jalr_done;
    logic [31:0] jalr_pc;
    logic        jump_en;
    logic [31:0] pc_jump;
    logic        br_en;
    logic [31:0] pc_branch;
    logic [31:0] imem_rdata;
    logic        imem_resp;
    logic        request_new_instr;
    logic [31:0] imem_addr;
    logic [3:0]  imem_rmask;
    iq_entry_t   instruction;
    logic [31:0] pc;
    logic        read_resp;

    logic [31:0] lfsr;      // decode gap source
    logic [31:0] exp_pc;    // next pc decode should see
    logic [31:0] last_word; // word of the last popped entry
    int          errors;
    int          timeouts;

    fetch fetch_inst (.*);

    imem_model imem_model_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return addr ^ WORD_KEY;
    endfunction

    task automatic rand_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr); // one step per bit
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic note_timeout(input string msg);
        timeouts++;
        $display("timeout at %0t ns: gave up waiting for %s", $time, msg);
    endtask

    task automatic check_entry(input iq_entry_t e, input string what);
        if (e.pc !== exp_pc)
            flag_mismatch($sformatf("%s: pc %h, expected %h", what, e.pc, exp_pc));
        if (e.instr !== word_at(e.pc))
            flag_mismatch($sformatf("%s: word %h at %h, expected %h",
                                    what, e.instr, e.pc, word_at(e.pc)));
        last_word = e.instr;
        exp_pc    = exp_pc + 32'd4; // sequential order
    endtask

    // holds the request until decode gets a head that pops at the next edge
    task automatic pop_entry(output iq_entry_t e, output bit got);
        int waited;
        got    = 1'b0;
        waited = 0;
        e      = '0;
        @(posedge clk);
        request_new_instr <= 1'b1;
        while (!got && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            if (read_resp)
            begin
                e   = instruction;
                got = 1'b1;
            end
            waited++;
        end
        @(posedge clk);
        request_new_instr <= 1'b0;
        if (!got)
            note_timeout("an instruction at decode");
    endtask

    task automatic expect_next(input string what);
        iq_entry_t e;
        bit        got;
        int        gap;
        rand_bits(2, gap); // 0 to 3 idle decode cycles
        repeat (gap) @(posedge clk);
        pop_entry(e, got);
        if (got)
            check_entry(e, what);
    endtask

    // pops every cycle until decode sees the queue empty
    task automatic empty_queue(output bit resp_at_empty);
        int waited;
        bit done;
        resp_at_empty = 1'b0;
        done          = 1'b0;
        waited        = 0;
        @(posedge clk);
        request_new_instr <= 1'b1;
        while (!done && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            if (read_resp)
            begin
                check_entry(instruction, "drain to empty");
            end
            else
            begin
                done          = 1'b1;
                resp_at_empty = imem_resp; // lands in the empty queue
            end
            waited++;
        end
        @(posedge clk);
        request_new_instr <= 1'b0;
        if (!done)
            note_timeout("the queue to run empty");
    endtask

    // sel is flush, jalr_done, jump_en, br_en
    task automatic redirect_pulse(input logic [3:0] sel, input logic [31:0] t_flush,
                                  input logic [31:0] t_jalr, input logic [31:0] t_jump,
                                  input logic [31:0] t_br);
        @(posedge clk);
        flush     <= sel[3];
        jalr_done <= sel[2];
        jump_en   <= sel[1];
        br_en     <= sel[0];
        missed_pc <= t_flush;
        jalr_pc   <= t_jalr;
        pc_jump   <= t_jump;
        pc_branch <= t_br;
        @(posedge clk);
        flush     <= 1'b0;
        jalr_done <= 1'b0;
        jump_en   <= 1'b0;
        br_en     <= 1'b0;
    endtask

    task automatic sequential_fetch();
        @(negedge clk); // first cycle with rst low
        if (imem_rmask !== IMEM_RMASK_WORD)
            flag_mismatch($sformatf("mask %b in the first cycle after reset, expected %b",
                                    imem_rmask, IMEM_RMASK_WORD));
        else if (imem_addr !== RESET_PC)
            flag_mismatch($sformatf("first read at %h, expected %h", imem_addr, RESET_PC));
        exp_pc = RESET_PC;
        repeat (8) expect_next("sequential");
    endtask

    task automatic backpressure_fill();
        bit resp_seen;
        int fills;
        int waited;
        empty_queue(resp_seen);
        fills  = resp_seen ? 1 : 0;
        waited = 0;
        while (fills < IQ_DEPTH && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            if (imem_resp)
                fills++; // every word is kept without a redirect
            waited++;
        end
        if (fills < IQ_DEPTH)
            note_timeout("the queue to fill");
        repeat (20)
        begin
            @(negedge clk);
            if (imem_rmask != 4'b0000)
                flag_mismatch($sformatf("read at %h with a full queue", imem_addr));
        end
        repeat (IQ_DEPTH) expect_next("drain full queue");
    endtask

    task automatic branch_redirect();
        redirect_pulse(4'b0001, 32'd0, 32'd0, 32'd0, 32'h6000_4000);
        exp_pc = 32'h6000_4000; // first entry must be the target
        repeat (4) expect_next("after branch");
    endtask

    task automatic redirect_priority();
        redirect_pulse(4'b1011, 32'h6000_8000, 32'd0, 32'h6000_9000, 32'h6000_a000);
        exp_pc = 32'h6000_8000; // flush wins
        repeat (3) expect_next("flush over jump and branch");
        redirect_pulse(4'b0110, 32'd0, 32'h6000_c000, 32'h6000_d000, 32'd0);
        exp_pc = 32'h6000_c000; // jalr_done wins
        repeat (3) expect_next("jalr over jump");
    endtask

    task automatic jalr_stall_resume();
        bit may_run;
        int resps;
        may_run = 1'b1;
        resps   = 0;
        @(posedge clk);
        jalr_en <= 1'b1;
        repeat (24)
        begin
            @(negedge clk);
            if (imem_rmask != 4'b0000 && !may_run)
                flag_mismatch($sformatf("read at %h during jalr stall", imem_addr));
            if (imem_rmask == 4'b0000 || imem_resp)
                may_run = 1'b0; // only the read already in flight may finish
            if (imem_resp)
                resps++;
            @(posedge clk);
            jalr_en <= 1'b0;
        end
        if (resps > 1)
            flag_mismatch($sformatf("%0d responses during jalr stall", resps));
        redirect_pulse(4'b0100, 32'd0, 32'h6001_2000, 32'd0, 32'd0);
        exp_pc = 32'h6001_2000;
        repeat (4) expect_next("after jalr");
    endtask

    task automatic stale_response_drop();
        bit          resp_seen;
        bit          found;
        int          waited;
        logic [31:0] stale_addr;
        empty_queue(resp_seen);
        found      = 1'b0;
        waited     = 0;
        stale_addr = 32'd0;
        while (!found && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            if (imem_rmask != 4'b0000 && !imem_resp)
            begin
                found      = 1'b1;
                stale_addr = imem_addr; // this word must be dropped
            end
            waited++;
        end
        if (!found)
            note_timeout("a pending read");
        redirect_pulse(4'b0010, 32'd0, 32'd0, 32'h6002_0000, 32'd0);
        exp_pc = 32'h6002_0000;
        repeat (4)
        begin
            expect_next("after jump over pending read");
            if (last_word === word_at(stale_addr))
                flag_mismatch($sformatf("stale word from %h reached decode", stale_addr));
        end
    endtask

    initial
    begin
        rst               = 1'b1;
        flush             = 1'b0;
        missed_pc         = 32'd0;
        jalr_en           = 1'b0;
        jalr_done         = 1'b0;
        jalr_pc           = 32'd0;
        jump_en           = 1'b0;
        pc_jump           = 32'd0;
        br_en             = 1'b0;
        pc_branch         = 32'd0;
        request_new_instr = 1'b0;
        lfsr              = LFSR_SEED;
        exp_pc            = RESET_PC;
        last_word         = 32'd0;
        errors            = 0;
        timeouts          = 0;
        repeat (3)
        begin
            @(negedge clk);
            if (imem_rmask != 4'b0000 || read_resp || pc !== RESET_PC)
                flag_mismatch("outputs not idle during reset");
        end
        @(posedge clk);
        rst <= 1'b0; // four reset edges seen
        sequential_fetch();
        backpressure_fill();
        branch_redirect();
        redirect_priority();
        jalr_stall_resume();
        stale_response_drop();
        $display("check failures: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* fetch.f */
src/rv32i_types.sv
src/pc_reg.sv
src/imem_req_ctrl.sv
src/instr_queue.sv
src/fetch.sv
bench/imem_model.sv
bench/fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        -f fetch.f --top-module fetch_tb \
        -Mdir obj_dir -o fetch_tb_sim > "$BUILD_LOG" 2>&1; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

if ! ./obj_dir/fetch_tb_sim > "$SIM_LOG" 2>&1; then
    echo "simulation exited with an error, see $SIM_LOG"
    exit 1
fi

if grep -q "ERRORS FOUND" "$SIM_LOG"; then
    echo "simulation FAILED, see $SIM_LOG"
    exit 1
fi

echo "simulation passed"
exit 0
